/* source/fm_pkg.sv */
// Shared definitions for the FM register map
// Register addresses of the global bank, the field widths that travel
// between blocks and the prescaler states. Modules import it inside
// their body and use scoped names in their port lists.
package fm_pkg;

    typedef logic [7:0]  reg_addr_t;     // Selected register
    typedef logic [7:0]  reg_data_t;     // CPU data byte
    typedef logic [10:0] fnum_t;         // Frequency number
    typedef logic [2:0]  block_t;        // Octave
    typedef logic [5:0]  fnum_hi_t;      // Block plus fnum[10:8]
    typedef logic [9:0]  timer_a_t;
    typedef logic [7:0]  timer_b_t;
    typedef logic [8:0]  pcm_t;          // DAC sample
    typedef logic [2:0]  ch_sel_t;       // {part, addr[1:0]}
    typedef logic [1:0]  op_sel_t;       // Operator slot from addr[3:2]

    // One-hot, bit 0 first: fnum-low, fb/alg, pms/ams
    typedef logic [2:0]  ch_upd_t;

    // One-hot, bit 0 first: dt1/mul, tl, ks/ar, am/dr, sr, sl/rr, ssg-eg
    typedef logic [6:0]  op_upd_t;

    // Prescaler ratio applied to cen
    typedef enum logic [1:0] {
        DIV6,
        DIV3,
        DIV2
    } div_mode_t;

    // Global register addresses
    localparam reg_addr_t REG_TESTYM  = 8'h21;
    localparam reg_addr_t REG_LFO     = 8'h22;
    localparam reg_addr_t REG_CLKA1   = 8'h24;  // Timer A high bits
    localparam reg_addr_t REG_CLKA2   = 8'h25;  // Timer A low bits
    localparam reg_addr_t REG_CLKB    = 8'h26;
    localparam reg_addr_t REG_TIMER   = 8'h27;
    localparam reg_addr_t REG_KON     = 8'h28;
    localparam reg_addr_t REG_PCM     = 8'h2A;
    localparam reg_addr_t REG_PCM_EN  = 8'h2B;
    localparam reg_addr_t REG_DACTEST = 8'h2C;

    // Prescaler select, acted on by the address write alone
    localparam reg_addr_t REG_CLK_N6  = 8'h2D;
    localparam reg_addr_t REG_CLK_N3  = 8'h2E;
    localparam reg_addr_t REG_CLK_N2  = 8'h2F;

    // Busy flag length in clk_en pulses
    localparam int BUSY_PULSES = 32;

endpackage

/* source/fm_clk_div.sv */
// Prescaler for the FM core
// Divides the incoming cen pulses by 6, 3 or 2 to form clk_en.
// The ratio is picked by address writes of 2D, 2E and 2F; the data
// phase plays no part in it.
`timescale 1ns/1ps

module fm_clk_div (
    input  logic             clk,
    input  logic             rst,
    input  logic             cen,
    input  logic             addr_wr,
    input  fm_pkg::reg_data_t din,
    output logic             clk_en
);
    import fm_pkg::*;

    div_mode_t  mode;
    div_mode_t  mode_nxt;
    logic [2:0] cnt;       // cen pulses seen in this period
    logic [2:0] last;      // Divisor minus one

    always_comb begin
        mode_nxt = mode;
        if (addr_wr) begin
            if (din == REG_CLK_N6)
                mode_nxt = DIV6;
            else if (din == REG_CLK_N3 && mode == DIV6)
                mode_nxt = DIV3;  // 2E only sets the low bit
            else if (din == REG_CLK_N2)
                mode_nxt = DIV2;
        end
    end

    always_comb begin
        case (mode)
            DIV6:    last = 3'd5;
            DIV3:    last = 3'd2;
            default: last = 3'd1;
        endcase
    end

    assign clk_en = cen && (cnt == last);

    always_ff @(posedge clk) begin
        if (rst) begin
            mode <= DIV6;
            cnt  <= 3'd0;
        end else begin
            mode <= mode_nxt;
            if (mode_nxt != mode)
                cnt <= 3'd0;                          // New ratio starts clean
            else if (cen)
                cnt <= (cnt == last) ? 3'd0 : cnt + 3'd1;
        end
    end

endmodule

/* source/fm_host_port.sv */
// CPU side of the register map
// Splits byte writes into the address phase (addr[0] low) and the data
// phase (addr[0] high), latches the selected register and its bank and
// keeps the busy flag for 32 clk_en pulses after a data write.
`timescale 1ns/1ps

module fm_host_port (
    input  logic              clk,
    input  logic              rst,
    input  logic              write,
    input  logic [1:0]        addr,
    input  fm_pkg::reg_data_t din,
    input  logic              clk_en,
    output logic              addr_wr,
    output logic              data_wr,
    output fm_pkg::reg_addr_t sel_reg,
    output logic              part,
    output logic              busy
);
    import fm_pkg::*;

    logic       prev_write;
    logic [4:0] busy_cnt;
    logic       data_start;

    assign addr_wr = write && !addr[0];
    assign data_wr = write && addr[0];

    // Busy only starts on the rising edge of a data write
    assign data_start = data_wr && !prev_write;

    always_ff @(posedge clk) begin
        if (rst) begin
            prev_write <= 1'b0;
            sel_reg    <= '0;
            part       <= 1'b0;
        end else begin
            prev_write <= write;
            if (addr_wr) begin
                sel_reg <= din;
                part    <= addr[1];  // Upper bank
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            busy_cnt <= 5'd0;
        end else if (data_start) begin
            busy     <= 1'b1;
            busy_cnt <= 5'd0;
        end else if (busy && clk_en) begin
            // Last pulse of the busy window
            if (busy_cnt == 5'(BUSY_PULSES - 1))
                busy <= 1'b0;
            busy_cnt <= busy_cnt + 5'd1;
        end
    end

endmodule

/* source/fm_global_regs.sv */
// Global registers of the FM chip
// Timers, LFO, test bits, CSM/effect mode and the PCM DAC. Bank 0 data
// writes update the global map; PCM registers answer in either bank.
// clr_flag_a/b and pcm_wr are one-shot and drop on the next clk_en
// that comes without a data write.
`timescale 1ns/1ps

module fm_global_regs (
    input  logic              clk,
    input  logic              rst,
    input  logic              clk_en,
    input  logic              data_wr,
    input  fm_pkg::reg_addr_t sel_reg,
    input  logic              part,
    input  fm_pkg::reg_data_t din,
    output fm_pkg::timer_a_t  value_a,
    output fm_pkg::timer_b_t  value_b,
    output logic              load_a,
    output logic              load_b,
    output logic              enable_irq_a,
    output logic              enable_irq_b,
    output logic              clr_flag_a,
    output logic              clr_flag_b,
    output logic              fast_timers,
    output logic              eg_stop,
    output logic              pg_stop,
    output logic              lfo_en,
    output logic              csm,
    output logic              effect,
    output logic [2:0]        lfo_freq,
    output fm_pkg::pcm_t      pcm,
    output logic              pcm_en,
    output logic              pcm_wr
);
    import fm_pkg::*;

    always_ff @(posedge clk) begin
        if (rst) begin
            value_a      <= '0;
            value_b      <= '0;
            load_a       <= 1'b0;
            load_b       <= 1'b0;
            enable_irq_a <= 1'b0;
            enable_irq_b <= 1'b0;
            clr_flag_a   <= 1'b0;
            clr_flag_b   <= 1'b0;
            fast_timers  <= 1'b0;
            eg_stop      <= 1'b0;
            pg_stop      <= 1'b0;
            lfo_en       <= 1'b0;
            lfo_freq     <= 3'd0;
            csm          <= 1'b0;
            effect       <= 1'b0;
            pcm          <= '0;
            pcm_en       <= 1'b0;
            pcm_wr       <= 1'b0;
        end else if (data_wr) begin
            if (!part) begin
                case (sel_reg)
                    REG_TESTYM: begin
                        eg_stop     <= din[5];
                        pg_stop     <= din[3];
                        fast_timers <= din[2];
                    end
                    REG_LFO:   {lfo_en, lfo_freq} <= din[3:0];
                    REG_CLKA1: value_a[9:2] <= din;
                    REG_CLKA2: value_a[1:0] <= din[1:0];
                    REG_CLKB:  value_b      <= din;
                    REG_TIMER: begin
                        effect <= |din[7:6];
                        csm    <= (din[7:6] == 2'b10);  // CSM implies effect
                        {clr_flag_b, clr_flag_a, enable_irq_b, enable_irq_a,
                         load_b, load_a} <= din[5:0];
                    end
                    default: ;
                endcase
            end

            // DAC path, bank ignored
            case (sel_reg)
                REG_PCM:     pcm    <= {~din[7], din[6:0], 1'b1};  // Offset binary
                REG_PCM_EN:  pcm_en <= din[7];
                REG_DACTEST: pcm[0] <= din[3];
                default: ;
            endcase
            pcm_wr <= (sel_reg == REG_PCM);
        end else if (clk_en) begin
            // One-shot bits
            clr_flag_a <= 1'b0;
            clr_flag_b <= 1'b0;
            pcm_wr     <= 1'b0;
        end
    end

endmodule

/* source/fm_ch3_freq.sv */
// Channel 3 per-operator frequencies
// Writes to A4-A6 and AC-AE fill one shared latch with block and the top
// fnum bits. The following low byte write to A9, AA or A8 commits the
// latch and the byte to operator 1, 2 or 3.
`timescale 1ns/1ps

module fm_ch3_freq (
    input  logic              clk,
    input  logic              rst,
    input  logic              data_wr,
    input  fm_pkg::reg_addr_t sel_reg,
    input  fm_pkg::reg_data_t din,
    output fm_pkg::fnum_t     fnum_ch3op1,
    output fm_pkg::fnum_t     fnum_ch3op2,
    output fm_pkg::fnum_t     fnum_ch3op3,
    output fm_pkg::block_t    block_ch3op1,
    output fm_pkg::block_t    block_ch3op2,
    output fm_pkg::block_t    block_ch3op3,
    output fm_pkg::fnum_hi_t  latch_fnum
);

    always_ff @(posedge clk) begin
        if (rst) begin
            latch_fnum   <= '0;
            fnum_ch3op1  <= '0;
            fnum_ch3op2  <= '0;
            fnum_ch3op3  <= '0;
            block_ch3op1 <= '0;
            block_ch3op2 <= '0;
            block_ch3op3 <= '0;
        end else if (data_wr) begin
            case (sel_reg)
                // Single latch shared by all channels
                8'hA4, 8'hA5, 8'hA6,
                8'hAC, 8'hAD, 8'hAE: latch_fnum <= din[5:0];
                8'hA9: {block_ch3op1, fnum_ch3op1} <= {latch_fnum, din};
                8'hAA: {block_ch3op2, fnum_ch3op2} <= {latch_fnum, din};
                8'hA8: {block_ch3op3, fnum_ch3op3} <= {latch_fnum, din};  // Op 3 sits at A8
                default: ;
            endcase
        end
    end

endmodule

/* source/fm_update_decode.sv */
// Update strobes for an external per-channel register file
// Every data write re-evaluates the strobes from the selected register,
// together with the channel and operator it points at and a copy of the
// byte. Outputs hold until the next data write.
`timescale 1ns/1ps

module fm_update_decode (
    input  logic              clk,
    input  logic              rst,
    input  logic              data_wr,
    input  fm_pkg::reg_addr_t sel_reg,
    input  logic              part,
    input  fm_pkg::reg_data_t din,
    output fm_pkg::ch_upd_t   up_chreg,
    output fm_pkg::op_upd_t   up_opreg,
    output logic              up_keyon,
    output fm_pkg::ch_sel_t   up_ch,
    output fm_pkg::op_sel_t   up_op,
    output fm_pkg::reg_data_t reg_data
);
    import fm_pkg::*;

    ch_upd_t ch_nxt;
    op_upd_t op_nxt;

    always_comb begin
        ch_nxt = '0;
        op_nxt = '0;
        // Slot 3 of each group does not exist
        if (sel_reg[1:0] != 2'b11) begin
            casez (sel_reg)
                8'hA0, 8'hA1, 8'hA2: ch_nxt = 3'b001;  // fnum low
                8'hB0, 8'hB1, 8'hB2: ch_nxt = 3'b010;  // fb / alg
                8'hB4, 8'hB5, 8'hB6: ch_nxt = 3'b100;  // pms / ams
                8'b0011_????: op_nxt = 7'h01;
                8'b0100_????: op_nxt = 7'h02;
                8'b0101_????: op_nxt = 7'h04;
                8'b0110_????: op_nxt = 7'h08;
                8'b0111_????: op_nxt = 7'h10;
                8'b1000_????: op_nxt = 7'h20;
                8'b1001_????: op_nxt = 7'h40;          // SSG-EG
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            up_chreg <= '0;
            up_opreg <= '0;
            up_keyon <= 1'b0;
            up_ch    <= '0;
            up_op    <= '0;
        end else if (data_wr) begin
            up_chreg <= ch_nxt;
            up_opreg <= op_nxt;
            up_keyon <= (sel_reg == REG_KON) && !part;
            up_ch    <= {part, sel_reg[1:0]};
            up_op    <= sel_reg[3:2];  // 0=S1 1=S3 2=S2 3=S4
        end
    end

    always_ff @(posedge clk) begin
        if (data_wr)
            reg_data <= din;
    end

endmodule

/* source/fm_mmr.sv */
// Host register map of the FM chip, top level
// Connects the prescaler, the CPU port, the global registers, the
// channel 3 frequency block and the update decoder. Drive write/addr/din
// from the CPU bus and cen from the chip clock enable.
`timescale 1ns/1ps

module fm_mmr (
    input  logic              clk,
    input  logic              rst,
    input  logic              cen,
    input  logic              write,
    input  logic [1:0]        addr,
    input  fm_pkg::reg_data_t din,
    output logic              busy,
    output logic              clk_en,
    // Global registers
    output fm_pkg::timer_a_t  value_a,
    output fm_pkg::timer_b_t  value_b,
    output logic              load_a,
    output logic              load_b,
    output logic              enable_irq_a,
    output logic              enable_irq_b,
    output logic              clr_flag_a,
    output logic              clr_flag_b,
    output logic              fast_timers,
    output logic              eg_stop,
    output logic              pg_stop,
    output logic              lfo_en,
    output logic              csm,
    output logic              effect,
    output logic [2:0]        lfo_freq,
    output fm_pkg::pcm_t      pcm,
    output logic              pcm_en,
    output logic              pcm_wr,
    // Channel 3 special mode
    output fm_pkg::fnum_t     fnum_ch3op1,
    output fm_pkg::fnum_t     fnum_ch3op2,
    output fm_pkg::fnum_t     fnum_ch3op3,
    output fm_pkg::block_t    block_ch3op1,
    output fm_pkg::block_t    block_ch3op2,
    output fm_pkg::block_t    block_ch3op3,
    output fm_pkg::fnum_hi_t  latch_fnum,
    // Register file updates
    output fm_pkg::ch_upd_t   up_chreg,
    output fm_pkg::op_upd_t   up_opreg,
    output logic              up_keyon,
    output fm_pkg::ch_sel_t   up_ch,
    output fm_pkg::op_sel_t   up_op,
    output fm_pkg::reg_data_t reg_data
);
    import fm_pkg::*;

    logic      addr_wr;
    logic      data_wr;
    reg_addr_t sel_reg;
    logic      part;

    fm_clk_div u_div (
        .clk     (clk),
        .rst     (rst),
        .cen     (cen),
        .addr_wr (addr_wr),
        .din     (din),
        .clk_en  (clk_en)
    );

    fm_host_port u_port (
        .clk     (clk),
        .rst     (rst),
        .write   (write),
        .addr    (addr),
        .din     (din),
        .clk_en  (clk_en),
        .addr_wr (addr_wr),
        .data_wr (data_wr),
        .sel_reg (sel_reg),
        .part    (part),
        .busy    (busy)
    );

    fm_global_regs u_glob (
        .clk          (clk),
        .rst          (rst),
        .clk_en       (clk_en),
        .data_wr      (data_wr),
        .sel_reg      (sel_reg),
        .part         (part),
        .din          (din),
        .value_a      (value_a),
        .value_b      (value_b),
        .load_a       (load_a),
        .load_b       (load_b),
        .enable_irq_a (enable_irq_a),
        .enable_irq_b (enable_irq_b),
        .clr_flag_a   (clr_flag_a),
        .clr_flag_b   (clr_flag_b),
        .fast_timers  (fast_timers),
        .eg_stop      (eg_stop),
        .pg_stop      (pg_stop),
        .lfo_en       (lfo_en),
        .csm          (csm),
        .effect       (effect),
        .lfo_freq     (lfo_freq),
        .pcm          (pcm),
        .pcm_en       (pcm_en),
        .pcm_wr       (pcm_wr)
    );

    fm_ch3_freq u_ch3 (
        .clk          (clk),
        .rst          (rst),
        .data_wr      (data_wr),
        .sel_reg      (sel_reg),
        .din          (din),
        .fnum_ch3op1  (fnum_ch3op1),
        .fnum_ch3op2  (fnum_ch3op2),
        .fnum_ch3op3  (fnum_ch3op3),
        .block_ch3op1 (block_ch3op1),
        .block_ch3op2 (block_ch3op2),
        .block_ch3op3 (block_ch3op3),
        .latch_fnum   (latch_fnum)
    );

    fm_update_decode u_dec (
        .clk      (clk),
        .rst      (rst),
        .data_wr  (data_wr),
        .sel_reg  (sel_reg),
        .part     (part),
        .din      (din),
        .up_chreg (up_chreg),
        .up_opreg (up_opreg),
        .up_keyon (up_keyon),
        .up_ch    (up_ch),
        .up_op    (up_op),
        .reg_data (reg_data)
    );

endmodule

/* bench/fm_mmr_checker.sv */
// Protocol assertions for the FM register map
// Bound into fm_mmr. Checks the shape of the update strobes and the
// behavior of clk_en and busy around reset.
`timescale 1ns/1ps

module fm_mmr_checker (
    input logic            clk,
    input logic            rst,
    input logic            cen,
    input logic            busy,
    input logic            clk_en,
    input fm_pkg::ch_upd_t up_chreg,
    input fm_pkg::op_upd_t up_opreg
);
    import fm_pkg::*;

    // Strobes are one-hot or idle
    ch_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(up_chreg))
        else $error("up_chreg has more than one bit set");
    op_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(up_opreg))
        else $error("up_opreg has more than one bit set");
    no_overlap: assert property (@(posedge clk) disable iff (rst) !(|up_chreg && |up_opreg))
        else $error("channel and operator strobes active together");

    reset_quiet: assert property (@(posedge clk) rst |=> !busy && !clk_en)
        else $error("busy or clk_en high in the cycle after reset");

    en_needs_cen: assert property (@(posedge clk) clk_en |-> cen)
        else $error("clk_en raised without cen");

endmodule

bind fm_mmr fm_mmr_checker u_chk (
    .clk      (clk),
    .rst      (rst),
    .cen      (cen),
    .busy     (busy),
    .clk_en   (clk_en),
    .up_chreg (up_chreg),
    .up_opreg (up_opreg)
);

/* bench/tb_fm_mmr.sv */
// Testbench for the FM host register map
// Drives random CPU writes and a random cen stream into fm_mmr, keeps a
// model of the register map and the prescaler, and compares the outputs
// one cycle after every data write. Built and run through the Makefile.
`timescale 1ns/1ps

module tb_fm_mmr;
    import fm_pkg::*;

    localparam int WAIT_LIMIT = 2000;  // Cycles before a wait gives up

    logic       clk = 1'b0;
    logic       rst = 1'b1;
    logic       cen = 1'b0;
    logic       write = 1'b0;
    logic [1:0] addr = 2'b00;
    reg_data_t  din = '0;

    logic       busy, clk_en;
    timer_a_t   value_a;
    timer_b_t   value_b;
    logic       load_a, load_b, enable_irq_a, enable_irq_b, clr_flag_a, clr_flag_b;
    logic       fast_timers, eg_stop, pg_stop, lfo_en, csm, effect, pcm_en, pcm_wr;
    logic [2:0] lfo_freq;
    pcm_t       pcm;
    fnum_t      fnum_ch3op1, fnum_ch3op2, fnum_ch3op3;
    block_t     block_ch3op1, block_ch3op2, block_ch3op3;
    fnum_hi_t   latch_fnum;
    ch_upd_t    up_chreg;
    op_upd_t    up_opreg;
    logic       up_keyon;
    ch_sel_t    up_ch;
    op_sel_t    up_op;
    reg_data_t  reg_data;

    // Reference model state
    int          m_div;       // Prescaler ratio
    reg_addr_t   m_sel;
    logic        m_part;
    timer_a_t    m_value_a;
    timer_b_t    m_value_b;
    logic [3:0]  m_tctl;      // enable_irq_b, enable_irq_a, load_b, load_a
    logic [2:0]  m_test;      // eg_stop, pg_stop, fast_timers
    logic [3:0]  m_lfo;
    logic [1:0]  m_mode;      // csm, effect
    pcm_t        m_pcm;
    logic        m_pcm_en;
    fnum_hi_t    m_latch;
    logic [13:0] m_op1, m_op2, m_op3;  // Block over fnum
    ch_upd_t     m_chreg;
    op_upd_t     m_opreg;
    logic        m_keyon;
    ch_sel_t     m_ch;
    op_sel_t     m_op;
    reg_data_t   m_data;

    int errors = 0;
    int test_errs = 0;
    int checks = 0;

    fm_mmr dut_i (.*);

    always #50 clk = ~clk;

    always @(posedge clk)
        cen <= ($urandom % 4) != 0;  // About 3/4 density

    task automatic check(input string name, input logic [31:0] act, input logic [31:0] exp);
        checks++;
        if (act !== exp) begin
            $display("CHECK FAILED at %0t ns: %s = %0h, expected %0h", $time, name, act, exp);
            errors++;
            test_errs++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout after %0d cycles waiting for %s", WAIT_LIMIT, what);
        errors++;
        test_errs++;
    endtask

    function automatic ch_upd_t chreg_for(input reg_addr_t a);
        if (a[1:0] == 2'b11)
            return '0;
        if (a[7:2] == 6'b101000)
            return 3'b001;                  // A0-A2
        if (a[7:2] == 6'b101100)
            return 3'b010;                  // B0-B2
        if (a[7:2] == 6'b101101)
            return 3'b100;                  // B4-B6
        return '0;
    endfunction

    function automatic op_upd_t opreg_for(input reg_addr_t a);
        int grp;
        grp = int'(a[7:4]);
        if (a[1:0] == 2'b11 || grp < 3 || grp > 9)
            return '0;
        return op_upd_t'(1 << (grp - 3));  // 3x first, 9x last
    endfunction

    task automatic clear_model();
        m_div = 6;
        m_sel = '0;
        m_part = 1'b0;
        m_value_a = '0;
        m_value_b = '0;
        m_tctl = '0;
        m_test = '0;
        m_lfo = '0;
        m_mode = '0;
        m_pcm = '0;
        m_pcm_en = 1'b0;
        m_latch = '0;
        m_op1 = '0;
        m_op2 = '0;
        m_op3 = '0;
    endtask

    task automatic note_addr_write(input logic bank, input reg_addr_t a);
        m_sel = a;
        m_part = bank;
        if (a == 8'h2D)
            m_div = 6;
        else if (a == 8'h2E && m_div == 6)
            m_div = 3;
        else if (a == 8'h2F)
            m_div = 2;
    endtask

    task automatic predict_data_write(input reg_data_t d);
        if (!m_part) begin
            case (m_sel)
                8'h21: m_test = {d[5], d[3], d[2]};
                8'h22: m_lfo = d[3:0];
                8'h24: m_value_a[9:2] = d;
                8'h25: m_value_a[1:0] = d[1:0];
                8'h26: m_value_b = d;
                8'h27: begin
                    m_mode = {d[7] & ~d[6], d[7] | d[6]};
                    m_tctl = d[3:0];
                end
                default: ;
            endcase
        end
        // Bank plays no part here
        case (m_sel)
            8'hA4, 8'hA5, 8'hA6, 8'hAC, 8'hAD, 8'hAE: m_latch = d[5:0];
            8'hA9: m_op1 = {m_latch, d};
            8'hAA: m_op2 = {m_latch, d};
            8'hA8: m_op3 = {m_latch, d};
            8'h2A: m_pcm = {~d[7], d[6:0], 1'b1};  // Sign flipped, low bit set
            8'h2B: m_pcm_en = d[7];
            8'h2C: m_pcm[0] = d[3];
            default: ;
        endcase
        m_chreg = chreg_for(m_sel);
        m_opreg = opreg_for(m_sel);
        m_keyon = (m_sel == 8'h28) && !m_part;
        m_ch = {m_part, m_sel[1:0]};
        m_op = m_sel[3:2];
        m_data = d;
    endtask

    // Address phase only, ends on the falling edge after the write
    task automatic select_reg(input logic bank, input reg_addr_t a);
        @(posedge clk);
        write <= 1'b1;
        addr  <= {bank, 1'b0};
        din   <= a;
        @(posedge clk);
        write <= 1'b0;
        note_addr_write(bank, a);
        @(negedge clk);
    endtask

    task automatic write_reg(input logic bank, input reg_addr_t a, input reg_data_t d);
        select_reg(bank, a);
        @(posedge clk);                     // Idle cycle so write rises again
        write <= 1'b1;
        addr  <= {bank, 1'b1};
        din   <= d;
        @(posedge clk);
        write <= 1'b0;
        predict_data_write(d);
        @(negedge clk);
    endtask

    task automatic check_outputs();
        check("value_a", 32'(value_a), 32'(m_value_a));
        check("value_b", 32'(value_b), 32'(m_value_b));
        check("enable_irq_b/a load_b/a",
              32'({enable_irq_b, enable_irq_a, load_b, load_a}), 32'(m_tctl));
        check("eg_stop/pg_stop/fast_timers", 32'({eg_stop, pg_stop, fast_timers}),
              32'(m_test));
        check("lfo_en/lfo_freq", 32'({lfo_en, lfo_freq}), 32'(m_lfo));
        check("csm/effect", 32'({csm, effect}), 32'(m_mode));
        check("pcm", 32'(pcm), 32'(m_pcm));
        check("pcm_en", 32'(pcm_en), 32'(m_pcm_en));
        check("latch_fnum", 32'(latch_fnum), 32'(m_latch));
        check("block/fnum ch3op1", 32'({block_ch3op1, fnum_ch3op1}), 32'(m_op1));
        check("block/fnum ch3op2", 32'({block_ch3op2, fnum_ch3op2}), 32'(m_op2));
        check("block/fnum ch3op3", 32'({block_ch3op3, fnum_ch3op3}), 32'(m_op3));
        check("up_chreg", 32'(up_chreg), 32'(m_chreg));
        check("up_opreg", 32'(up_opreg), 32'(m_opreg));
        check("up_keyon", 32'(up_keyon), 32'(m_keyon));
        check("up_ch", 32'(up_ch), 32'(m_ch));
        check("up_op", 32'(up_op), 32'(m_op));
        check("reg_data", 32'(reg_data), 32'(m_data));
    endtask

    task automatic wait_clk_en();
        int n;
        n = 0;
        while (!clk_en && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!clk_en)
            report_timeout("clk_en");
    endtask

    // cen pulses from one clk_en up to and including the next
    task automatic measure_gap(output int gap);
        int n;
        wait_clk_en();
        gap = 0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (cen)
                gap++;
        end while (!clk_en && n < WAIT_LIMIT);
        if (!clk_en)
            report_timeout("the next clk_en");
    endtask

    task automatic end_test(input string name);
        $display("%s: %0d errors", name, test_errs);
        test_errs = 0;
    endtask

    initial begin
        reg_addr_t a;
        reg_data_t d;
        int        r;
        int        gap;
        int        pulses;
        int        n;

        void'($urandom(32'h2cdb6723));
        clear_model();
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);

        // Prescaler ratio after reset, then 2F, 2D, 2E
        measure_gap(gap);
        check("clk_en gap after reset", 32'(gap), 32'(m_div));
        select_reg(1'b0, 8'h2F);
        measure_gap(gap);
        check("clk_en gap after 2F", 32'(gap), 32'(m_div));
        select_reg(1'b0, 8'h2D);
        measure_gap(gap);
        check("clk_en gap after 2D", 32'(gap), 32'(m_div));
        select_reg(1'b1, 8'h2E);
        measure_gap(gap);
        check("clk_en gap after 2E", 32'(gap), 32'(m_div));
        end_test("prescaler");

        repeat (40) begin
            r = $urandom % 6;
            a = (r < 2) ? 8'(8'h21 + r) : 8'(8'h22 + r);  // 21 22 24 25 26 27
            write_reg(($urandom % 4) == 0, a, 8'($urandom));
            check_outputs();
        end
        end_test("global registers");

        repeat (30) begin
            a = 8'(8'h2A + $urandom % 3);
            write_reg(1'($urandom % 2), a, 8'($urandom));
            check_outputs();
            check("pcm_wr", 32'(pcm_wr), 32'(a == 8'h2A));
            if (a == 8'h2A) begin
                wait_clk_en();
                @(negedge clk);
                check("pcm_wr after clk_en", 32'(pcm_wr), 32'd0);
            end
        end
        repeat (10) begin
            d = 8'($urandom);
            write_reg(1'b0, 8'h27, d);
            check_outputs();
            check("clr_flag_b/a", 32'({clr_flag_b, clr_flag_a}), 32'(d[5:4]));
            wait_clk_en();
            @(negedge clk);
            check("clr_flag_b/a after clk_en", 32'({clr_flag_b, clr_flag_a}), 32'd0);
        end
        end_test("pcm and one-shot bits");

        repeat (30) begin
            a = 8'(8'hA4 + $urandom % 3 + 8 * ($urandom % 2));  // A4-A6 or AC-AE
            write_reg(1'b0, a, 8'($urandom));
            check_outputs();
            write_reg(1'b0, 8'(8'hA8 + $urandom % 3), 8'($urandom));
            check_outputs();
        end
        end_test("channel 3 frequencies");

        repeat (80) begin
            r = $urandom % 4;
            if (r == 0)
                a = 8'h28;                        // Key-on, either bank
            else if (r < 3)
                a = 8'(8'h30 + $urandom % 144);   // Strobe ranges 30-BF
            else
                a = 8'($urandom);
            write_reg(1'($urandom % 2), a, 8'($urandom));
            check_outputs();
        end
        end_test("update decode");

        // Let any earlier busy window run out first
        n = 0;
        while (busy && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (busy)
            report_timeout("busy to clear before the busy test");
        write_reg(1'b0, 8'hB3, 8'($urandom));
        check_outputs();
        check("busy after data write", 32'(busy), 32'd1);
        pulses = 0;
        n = 0;
        while (busy && n < WAIT_LIMIT) begin
            if (clk_en)
                pulses++;
            @(negedge clk);
            n++;
        end
        if (busy)
            report_timeout("busy to fall");
        check("clk_en pulses while busy", 32'(pulses), 32'd32);
        end_test("busy flag");

        $display("tests: 6, checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

/* fm_mmr.f */
source/fm_pkg.sv
source/fm_clk_div.sv
source/fm_host_port.sv
source/fm_global_regs.sv
source/fm_ch3_freq.sv
source/fm_update_decode.sv
source/fm_mmr.sv
bench/fm_mmr_checker.sv
bench/tb_fm_mmr.sv

/* Makefile */
# Verilator build and run of the FM register map testbench

SIM := obj_dir/Vtb_fm_mmr

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): fm_mmr.f $(wildcard source/*.sv bench/*.sv)
	verilator --binary --timing --assert --top-module tb_fm_mmr -f fm_mmr.f

run: $(SIM)
	./$(SIM) > sim.log 2>&1; cat sim.log
	@if grep -qF '*** FAILED ***' sim.log; then exit 1; fi
	@grep -qF '*** PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log
